// ==== exu_isa_pkg.sv ====
`default_nettype none

package exu_isa_pkg;

  localparam int CPU_WIDTH      = 32;
  localparam int CSR_ADDR_WIDTH = 12;

  // Execute operations as issued by decode
  typedef enum logic [4:0] {
    EXU_ADD  = 5'd0,
    EXU_SUB  = 5'd1,
    EXU_SLL  = 5'd2,
    EXU_SRL  = 5'd3,
    EXU_SRA  = 5'd4,
    EXU_XOR  = 5'd5,
    EXU_OR   = 5'd6,
    EXU_AND  = 5'd7,
    EXU_SLT  = 5'd8,
    EXU_SLTU = 5'd9,
    EXU_BEQ  = 5'd10,
    EXU_BNE  = 5'd11,
    EXU_BLT  = 5'd12,
    EXU_BGE  = 5'd13,
    EXU_BLTU = 5'd14,
    EXU_BGEU = 5'd15
  } exu_opt_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SUBU = 4'd2,  // Same difference with the borrow from a 33-bit result
    ALU_SLL  = 4'd3,
    ALU_SRL  = 4'd4,
    ALU_SRA  = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_OR   = 4'd7,
    ALU_AND  = 4'd8
  } alu_opt_e;

  typedef enum logic [1:0] {
    SEL_REG = 2'd0,  // rs1, rs2
    SEL_IMM = 2'd1,  // rs1, imm
    SEL_PC4 = 2'd2,  // pc, 4
    SEL_PCI = 2'd3   // pc, imm
  } src_sel_e;

  typedef enum logic [1:0] {
    CSR_NOP = 2'd0,
    CSR_RW  = 2'd1,
    CSR_RS  = 2'd2,
    CSR_RC  = 2'd3
  } csr_opt_e;

  // Machine mode CSRs
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MCAUSE  = 12'h342;

endpackage

`default_nettype wire

// ==== exu_pkt_pkg.sv ====
`default_nettype none

package exu_pkt_pkg;

  // Issued instruction as held in the input slot
  typedef struct packed {
    logic [exu_isa_pkg::CPU_WIDTH-1:0]      pc;
    logic [exu_isa_pkg::CPU_WIDTH-1:0]      rs1;
    logic [exu_isa_pkg::CPU_WIDTH-1:0]      rs2;
    logic [exu_isa_pkg::CPU_WIDTH-1:0]      imm;
    exu_isa_pkg::src_sel_e                  src_sel;
    exu_isa_pkg::exu_opt_e                  opt;
    logic                                   sysins;   // CSR access instruction
    exu_isa_pkg::csr_opt_e                  csr_opt;
    logic                                   csr_src;  // Set selects imm as CSR source
    logic [exu_isa_pkg::CSR_ADDR_WIDTH-1:0] csr_addr;
  } exu_req_t;

  // Result as held in the output slot
  typedef struct packed {
    logic [exu_isa_pkg::CPU_WIDTH-1:0] res;
    logic                              zero;
  } exu_rsp_t;

endpackage

`default_nettype wire

// ==== csr_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface csr_if;

  logic [exu_isa_pkg::CSR_ADDR_WIDTH-1:0] raddr_waddr;  // Shared read and write address
  logic [exu_isa_pkg::CPU_WIDTH-1:0]      rdata;
  logic [exu_isa_pkg::CPU_WIDTH-1:0]      wdata;
  logic                                   we;

  modport exu_mp (
    output raddr_waddr,
    output wdata,
    output we,
    input  rdata
  );

  modport csr_mp (
    input  raddr_waddr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  logic [exu_isa_pkg::CPU_WIDTH-1:0] i_src1,
  input  logic [exu_isa_pkg::CPU_WIDTH-1:0] i_src2,
  input  exu_isa_pkg::alu_opt_e             i_opt,
  output logic [exu_isa_pkg::CPU_WIDTH-1:0] o_alu_res,
  output logic                              o_sububit
);

  localparam int W   = exu_isa_pkg::CPU_WIDTH;
  localparam int SHW = $clog2(W);

  logic [W:0]     diff_u;
  logic [SHW-1:0] shamt;

  // Top bit of the zero extended difference is the unsigned borrow
  assign diff_u    = {1'b0, i_src1} - {1'b0, i_src2};
  assign o_sububit = diff_u[W];

  assign shamt = i_src2[SHW-1:0];

  always_comb begin
    case (i_opt)
      exu_isa_pkg::ALU_ADD:  o_alu_res = i_src1 + i_src2;
      exu_isa_pkg::ALU_SUB,
      exu_isa_pkg::ALU_SUBU: o_alu_res = diff_u[W-1:0];
      exu_isa_pkg::ALU_SLL:  o_alu_res = i_src1 << shamt;
      exu_isa_pkg::ALU_SRL:  o_alu_res = i_src1 >> shamt;
      exu_isa_pkg::ALU_SRA:  o_alu_res = $signed(i_src1) >>> shamt;
      exu_isa_pkg::ALU_XOR:  o_alu_res = i_src1 ^ i_src2;
      exu_isa_pkg::ALU_OR:   o_alu_res = i_src1 | i_src2;
      exu_isa_pkg::ALU_AND:  o_alu_res = i_src1 & i_src2;
      default:               o_alu_res = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== exu.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu (
  input  exu_pkt_pkg::exu_req_t i_req,
  output exu_pkt_pkg::exu_rsp_t o_rsp,
  input  logic                  i_fire,
  csr_if.exu_mp                 csr
);

  localparam int W = exu_isa_pkg::CPU_WIDTH;

  logic [W-1:0]          src1, src2;
  logic [W-1:0]          alu_res, int_res;
  logic [W-1:0]          sys_src, sys_new, sys_rd;
  exu_isa_pkg::alu_opt_e alu_opt;
  logic                  sububit;
  logic                  less;
  logic                  is_cmp, cmp_bit;

  always_comb begin
    case (i_req.src_sel)
      exu_isa_pkg::SEL_REG: begin
        src1 = i_req.rs1;
        src2 = i_req.rs2;
      end
      exu_isa_pkg::SEL_IMM: begin
        src1 = i_req.rs1;
        src2 = i_req.imm;
      end
      exu_isa_pkg::SEL_PC4: begin
        src1 = i_req.pc;
        src2 = W'(4);  // Return address
      end
      default: begin
        src1 = i_req.pc;
        src2 = i_req.imm;
      end
    endcase
  end

  // Sign of src1 decides when the signs differ. Equal signs cannot overflow the difference
  assign less = (src1[W-1] ^ src2[W-1]) ? src1[W-1] : alu_res[W-1];

  always_comb begin
    alu_opt = exu_isa_pkg::ALU_ADD;
    is_cmp  = 1'b1;
    cmp_bit = 1'b0;
    case (i_req.opt)
      exu_isa_pkg::EXU_SLT,
      exu_isa_pkg::EXU_BLT: begin
        alu_opt = exu_isa_pkg::ALU_SUB;
        cmp_bit = less;
      end
      exu_isa_pkg::EXU_BGE: begin
        alu_opt = exu_isa_pkg::ALU_SUB;
        cmp_bit = ~less;
      end
      exu_isa_pkg::EXU_SLTU,
      exu_isa_pkg::EXU_BLTU: begin
        alu_opt = exu_isa_pkg::ALU_SUBU;
        cmp_bit = sububit;
      end
      exu_isa_pkg::EXU_BGEU: begin
        alu_opt = exu_isa_pkg::ALU_SUBU;
        cmp_bit = ~sububit;
      end
      exu_isa_pkg::EXU_BEQ: begin
        alu_opt = exu_isa_pkg::ALU_SUB;
        cmp_bit = ~(|alu_res);
      end
      exu_isa_pkg::EXU_BNE: begin
        alu_opt = exu_isa_pkg::ALU_SUB;
        cmp_bit = |alu_res;
      end
      exu_isa_pkg::EXU_SUB: begin
        alu_opt = exu_isa_pkg::ALU_SUB;
        is_cmp  = 1'b0;
      end
      exu_isa_pkg::EXU_SLL: begin
        alu_opt = exu_isa_pkg::ALU_SLL;
        is_cmp  = 1'b0;
      end
      exu_isa_pkg::EXU_SRL: begin
        alu_opt = exu_isa_pkg::ALU_SRL;
        is_cmp  = 1'b0;
      end
      exu_isa_pkg::EXU_SRA: begin
        alu_opt = exu_isa_pkg::ALU_SRA;
        is_cmp  = 1'b0;
      end
      exu_isa_pkg::EXU_XOR: begin
        alu_opt = exu_isa_pkg::ALU_XOR;
        is_cmp  = 1'b0;
      end
      exu_isa_pkg::EXU_OR: begin
        alu_opt = exu_isa_pkg::ALU_OR;
        is_cmp  = 1'b0;
      end
      exu_isa_pkg::EXU_AND: begin
        alu_opt = exu_isa_pkg::ALU_AND;
        is_cmp  = 1'b0;
      end
      default: is_cmp = 1'b0;  // ADD
    endcase
  end

  alu u_alu (
    .i_src1   (src1),
    .i_src2   (src2),
    .i_opt    (alu_opt),
    .o_alu_res(alu_res),
    .o_sububit(sububit)
  );

  assign int_res = is_cmp ? {{(W-1){1'b0}}, cmp_bit} : alu_res;

  // CSR read-modify-write
  assign sys_src = i_req.csr_src ? i_req.imm : i_req.rs1;
  assign sys_rd  = (i_req.csr_opt == exu_isa_pkg::CSR_NOP) ? '0 : csr.rdata;

  always_comb begin
    case (i_req.csr_opt)
      exu_isa_pkg::CSR_RW: sys_new = sys_src;
      exu_isa_pkg::CSR_RS: sys_new = csr.rdata | sys_src;
      exu_isa_pkg::CSR_RC: sys_new = csr.rdata & ~sys_src;
      default:             sys_new = csr.rdata;
    endcase
  end

  assign csr.raddr_waddr = i_req.csr_addr;
  assign csr.wdata       = sys_new;
  assign csr.we          = i_fire & i_req.sysins & (i_req.csr_opt != exu_isa_pkg::CSR_NOP);

  assign o_rsp.res  = i_req.sysins ? sys_rd : int_res;
  assign o_rsp.zero = ~(|int_res);

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_file #(
  parameter logic [exu_isa_pkg::CPU_WIDTH-1:0] MTVEC_RST = '0
) (
  input  logic  i_clk,
  input  logic  i_arst_n,
  csr_if.csr_mp csr
);

  localparam int W = exu_isa_pkg::CPU_WIDTH;

  logic [W-1:0] mstatus;
  logic [W-1:0] mtvec;
  logic [W-1:0] mepc;
  logic [W-1:0] mcause;

  always_comb begin
    case (csr.raddr_waddr)
      exu_isa_pkg::CSR_MSTATUS: csr.rdata = mstatus;
      exu_isa_pkg::CSR_MTVEC:   csr.rdata = mtvec;
      exu_isa_pkg::CSR_MEPC:    csr.rdata = mepc;
      exu_isa_pkg::CSR_MCAUSE:  csr.rdata = mcause;
      default:                  csr.rdata = '0;  // Unimplemented reads as zero
    endcase
  end

  // Write lands on the transfer edge of the owning instruction
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mstatus <= '0;
      mtvec   <= MTVEC_RST;
      mepc    <= '0;
      mcause  <= '0;
    end else if (csr.we) begin
      case (csr.raddr_waddr)
        exu_isa_pkg::CSR_MSTATUS: mstatus <= csr.wdata;
        exu_isa_pkg::CSR_MTVEC:   mtvec   <= csr.wdata;
        exu_isa_pkg::CSR_MEPC:    mepc    <= csr.wdata;
        exu_isa_pkg::CSR_MCAUSE:  mcause  <= csr.wdata;
        default: ;  // Dropped
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== exu_pipe_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_pipe_reg #(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_valid,
  output logic o_ready,
  input  T     i_data,
  output logic o_valid,
  input  logic i_ready,
  output T     o_data
);

  logic full;
  T     data_q;

  // Accepts while empty or while the held entry leaves
  assign o_ready = ~full | i_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= 1'b0;
    end else if (o_ready) begin
      full <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      data_q <= i_data;
    end
  end

  assign o_valid = full;
  assign o_data  = data_q;

endmodule

`default_nettype wire

// ==== exu_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_stage #(
  parameter logic [exu_isa_pkg::CPU_WIDTH-1:0] MTVEC_RST = '0
) (
  input  logic                                   i_clk,
  input  logic                                   i_arst_n,
  // Issue side
  input  logic                                   i_valid,
  output logic                                   o_ready,
  input  logic [exu_isa_pkg::CPU_WIDTH-1:0]      i_pc,
  input  logic [exu_isa_pkg::CPU_WIDTH-1:0]      i_rs1,
  input  logic [exu_isa_pkg::CPU_WIDTH-1:0]      i_rs2,
  input  logic [exu_isa_pkg::CPU_WIDTH-1:0]      i_imm,
  input  exu_isa_pkg::src_sel_e                  i_src_sel,
  input  exu_isa_pkg::exu_opt_e                  i_opt,
  input  logic                                   i_sysins,
  input  exu_isa_pkg::csr_opt_e                  i_csr_opt,
  input  logic                                   i_csr_src,
  input  logic [exu_isa_pkg::CSR_ADDR_WIDTH-1:0] i_csr_addr,
  // Result side
  output logic                                   o_valid,
  input  logic                                   i_ready,
  output logic [exu_isa_pkg::CPU_WIDTH-1:0]      o_res,
  output logic                                   o_zero
);

  exu_pkt_pkg::exu_req_t req_d, req_q;
  exu_pkt_pkg::exu_rsp_t rsp_d, rsp_q;
  logic                  req_valid;
  logic                  rsp_ready;

  csr_if csr_bus ();

  assign req_d.pc       = i_pc;
  assign req_d.rs1      = i_rs1;
  assign req_d.rs2      = i_rs2;
  assign req_d.imm      = i_imm;
  assign req_d.src_sel  = i_src_sel;
  assign req_d.opt      = i_opt;
  assign req_d.sysins   = i_sysins;
  assign req_d.csr_opt  = i_csr_opt;
  assign req_d.csr_src  = i_csr_src;
  assign req_d.csr_addr = i_csr_addr;

  exu_pipe_reg #(.T(exu_pkt_pkg::exu_req_t)) req_slot (
    .i_clk   (i_clk),
    .i_arst_n(i_arst_n),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .i_data  (req_d),
    .o_valid (req_valid),
    .i_ready (rsp_ready),
    .o_data  (req_q)
  );

  exu u_exu (
    .i_req (req_q),
    .o_rsp (rsp_d),
    .i_fire(req_valid & rsp_ready),  // Instruction retires into rsp_slot
    .csr   (csr_bus.exu_mp)
  );

  csr_file #(.MTVEC_RST(MTVEC_RST)) u_csr_file (
    .i_clk   (i_clk),
    .i_arst_n(i_arst_n),
    .csr     (csr_bus.csr_mp)
  );

  exu_pipe_reg #(.T(exu_pkt_pkg::exu_rsp_t)) rsp_slot (
    .i_clk   (i_clk),
    .i_arst_n(i_arst_n),
    .i_valid (req_valid),
    .o_ready (rsp_ready),
    .i_data  (rsp_d),
    .o_valid (o_valid),
    .i_ready (i_ready),
    .o_data  (rsp_q)
  );

  assign o_res  = rsp_q.res;
  assign o_zero = rsp_q.zero;

endmodule

`default_nettype wire

// ==== exu_stage_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_stage_chk (
  input logic                              i_clk,
  input logic                              i_arst_n,
  input logic                              i_rsp_valid,
  input logic                              i_rsp_ready,
  input logic [exu_isa_pkg::CPU_WIDTH-1:0] i_res,
  input logic                              i_zero,
  input logic                              i_csr_we,
  input logic                              i_req_valid
);

  a_no_valid_in_reset: assert property (
    @(posedge i_clk) !i_arst_n |-> !i_rsp_valid
  ) else $error("o_valid high during reset");

  // Stalled result holds until taken
  a_stall_holds: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_res) && $stable(i_zero))
  ) else $error("o_valid or result changed while stalled");

  // Output slot takes an entry when empty or when its result leaves
  a_we_on_move: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_csr_we |-> (i_req_valid && (!i_rsp_valid || i_rsp_ready))
  ) else $error("CSR write without a request moving");

endmodule

bind exu_stage exu_stage_chk chk_inst (
  .i_clk      (i_clk),
  .i_arst_n   (i_arst_n),
  .i_rsp_valid(o_valid),
  .i_rsp_ready(i_ready),
  .i_res      (o_res),
  .i_zero     (o_zero),
  .i_csr_we   (csr_bus.we),
  .i_req_valid(req_valid)
);

`default_nettype wire

// ==== tb_exu_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exu_stage;

  localparam int W           = exu_isa_pkg::CPU_WIDTH;
  localparam int AW          = exu_isa_pkg::CSR_ADDR_WIDTH;
  localparam int N_TXN       = 600;
  localparam int N_DIRECTED  = 6;
  localparam int TIMEOUT_CYC = N_TXN * 8;
  localparam logic [W-1:0] MTVEC_RST = '0;

  logic                  i_clk;
  logic                  i_arst_n;
  logic                  i_valid;
  logic                  o_ready;
  logic [W-1:0]          i_pc;
  logic [W-1:0]          i_rs1;
  logic [W-1:0]          i_rs2;
  logic [W-1:0]          i_imm;
  exu_isa_pkg::src_sel_e i_src_sel;
  exu_isa_pkg::exu_opt_e i_opt;
  logic                  i_sysins;
  exu_isa_pkg::csr_opt_e i_csr_opt;
  logic                  i_csr_src;
  logic [AW-1:0]         i_csr_addr;
  logic                  o_valid;
  logic                  i_ready;
  logic [W-1:0]          o_res;
  logic                  o_zero;

  logic [31:0]  lfsr;
  logic [W-1:0] shadow [4];  // Model of the four machine CSRs
  logic [W:0]   exp_q [$];   // {res, zero} in acceptance order
  int           acc_cnt, rsp_cnt, n_sent, err_cnt, chk_cnt, cyc;

  exu_stage #(.MTVEC_RST(MTVEC_RST)) exu_stage_inst (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (i_valid),
    .o_ready   (o_ready),
    .i_pc      (i_pc),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_imm     (i_imm),
    .i_src_sel (i_src_sel),
    .i_opt     (i_opt),
    .i_sysins  (i_sysins),
    .i_csr_opt (i_csr_opt),
    .i_csr_src (i_csr_src),
    .i_csr_addr(i_csr_addr),
    .o_valid   (o_valid),
    .i_ready   (i_ready),
    .o_res     (o_res),
    .o_zero    (o_zero)
  );

  always #2 i_clk = ~i_clk;

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Biased toward corner values
  function automatic logic [W-1:0] pick_operand();
    logic [31:0] t;
    t = take_bits(3);
    case (t[2:0])
      3'd0:    return '0;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'h7fff_ffff;
      3'd3:    return '1;
      default: return take_bits(32);
    endcase
  endfunction

  function automatic int csr_index(input logic [AW-1:0] addr);
    case (addr)
      exu_isa_pkg::CSR_MSTATUS: return 0;
      exu_isa_pkg::CSR_MTVEC:   return 1;
      exu_isa_pkg::CSR_MEPC:    return 2;
      exu_isa_pkg::CSR_MCAUSE:  return 3;
      default:                  return -1;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [W-1:0] got, input logic [W-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      err_cnt++;
    end
  endtask

  // Reference model run at the acceptance edge
  task automatic accept_request();
    logic [W-1:0] a, b, r, old, src, nv;
    int           idx;
    case (i_src_sel)
      exu_isa_pkg::SEL_REG: begin
        a = i_rs1;
        b = i_rs2;
      end
      exu_isa_pkg::SEL_IMM: begin
        a = i_rs1;
        b = i_imm;
      end
      exu_isa_pkg::SEL_PC4: begin
        a = i_pc;
        b = W'(4);
      end
      default: begin
        a = i_pc;
        b = i_imm;
      end
    endcase
    case (i_opt)
      exu_isa_pkg::EXU_SUB:  r = a - b;
      exu_isa_pkg::EXU_SLL:  r = a << b[4:0];
      exu_isa_pkg::EXU_SRL:  r = a >> b[4:0];
      exu_isa_pkg::EXU_SRA:  r = $signed(a) >>> b[4:0];
      exu_isa_pkg::EXU_XOR:  r = a ^ b;
      exu_isa_pkg::EXU_OR:   r = a | b;
      exu_isa_pkg::EXU_AND:  r = a & b;
      exu_isa_pkg::EXU_SLT,
      exu_isa_pkg::EXU_BLT:  r = W'($signed(a) < $signed(b));
      exu_isa_pkg::EXU_BGE:  r = W'($signed(a) >= $signed(b));
      exu_isa_pkg::EXU_SLTU,
      exu_isa_pkg::EXU_BLTU: r = W'(a < b);
      exu_isa_pkg::EXU_BGEU: r = W'(a >= b);
      exu_isa_pkg::EXU_BEQ:  r = W'(a == b);
      exu_isa_pkg::EXU_BNE:  r = W'(a != b);
      default:               r = a + b;
    endcase
    if (i_sysins) begin
      idx = csr_index(i_csr_addr);
      old = (i_csr_opt == exu_isa_pkg::CSR_NOP || idx < 0) ? '0 : shadow[idx];
      src = i_csr_src ? i_imm : i_rs1;
      case (i_csr_opt)
        exu_isa_pkg::CSR_RW: nv = src;
        exu_isa_pkg::CSR_RS: nv = old | src;
        exu_isa_pkg::CSR_RC: nv = old & ~src;
        default:             nv = old;
      endcase
      if (idx >= 0 && i_csr_opt != exu_isa_pkg::CSR_NOP) shadow[idx] = nv;
      exp_q.push_back({old, r == '0});
    end else begin
      exp_q.push_back({r, r == '0});
    end
    acc_cnt++;
  endtask

  task automatic compare_response();
    logic [W:0] exp;
    if (exp_q.size() == 0) begin
      $display("Response at cycle %0d without an outstanding request", cyc);
      err_cnt++;
    end else begin
      exp = exp_q.pop_front();
      check_val("o_res", o_res, exp[W:1]);
      check_val("o_zero", W'(o_zero), W'(exp[0]));
      rsp_cnt++;
    end
  endtask

  always @(posedge i_clk) begin
    if (i_arst_n) begin
      if (o_valid && i_ready) compare_response();
      if (i_valid && o_ready) accept_request();
    end
  end

  always @(posedge i_clk) begin
    cyc++;
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, %0d of %0d responses seen", cyc, rsp_cnt, N_TXN);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic load_random_request();
    logic [31:0] t;
    t          = take_bits(30);
    i_pc       = {t[29:0], 2'b00};
    i_rs1      = pick_operand();
    t          = take_bits(2);
    case (t[1:0])
      2'd0:    i_rs2 = i_rs1;                 // Equal operands
      2'd1:    i_rs2 = i_rs1 ^ 32'h8000_0000; // Opposite signs
      default: i_rs2 = pick_operand();
    endcase
    t          = take_bits(2);
    i_imm      = (t[1:0] == 2'd0) ? i_rs1 : pick_operand();
    t          = take_bits(2);
    i_src_sel  = exu_isa_pkg::src_sel_e'(t[1:0]);
    t          = take_bits(4);
    i_opt      = exu_isa_pkg::exu_opt_e'({1'b0, t[3:0]});
    t          = take_bits(2);
    i_sysins   = (t[1:0] == 2'd0);
    t          = take_bits(2);
    i_csr_opt  = exu_isa_pkg::csr_opt_e'(t[1:0]);
    t          = take_bits(1);
    i_csr_src  = t[0];
    t          = take_bits(3);
    case (t[2:0])
      3'd0:    i_csr_addr = exu_isa_pkg::CSR_MSTATUS;
      3'd1:    i_csr_addr = exu_isa_pkg::CSR_MTVEC;
      3'd2:    i_csr_addr = exu_isa_pkg::CSR_MEPC;
      3'd3:    i_csr_addr = exu_isa_pkg::CSR_MCAUSE;
      3'd4:    i_csr_addr = 12'h340;  // Not implemented
      default: begin
        t          = take_bits(AW);
        i_csr_addr = t[AW-1:0];
      end
    endcase
  endtask

  task automatic set_csr_request(input exu_isa_pkg::csr_opt_e op, input logic use_imm,
                                 input logic [AW-1:0] addr, input logic [W-1:0] value);
    i_sysins   = 1'b1;
    i_csr_opt  = op;
    i_csr_src  = use_imm;
    i_csr_addr = addr;
    i_rs1      = value;
    i_imm      = value;
  endtask

  // Holds i_valid from a falling edge until the falling edge after acceptance
  task automatic issue_and_wait();
    int seen;
    seen    = acc_cnt;
    i_valid = 1'b1;
    do @(negedge i_clk); while (acc_cnt == seen);
    i_valid = 1'b0;
  endtask

  initial begin
    logic [31:0] t;
    int          seen;
    i_clk      = 1'b0;
    i_arst_n   = 1'b0;
    i_valid    = 1'b0;
    i_ready    = 1'b0;
    i_pc       = '0;
    i_rs1      = '0;
    i_rs2      = '0;
    i_imm      = '0;
    i_src_sel  = exu_isa_pkg::SEL_REG;
    i_opt      = exu_isa_pkg::EXU_ADD;
    i_sysins   = 1'b0;
    i_csr_opt  = exu_isa_pkg::CSR_NOP;
    i_csr_src  = 1'b0;
    i_csr_addr = '0;
    lfsr       = 32'he2b7c11a;
    acc_cnt    = 0;
    rsp_cnt    = 0;
    n_sent     = 0;
    err_cnt    = 0;
    chk_cnt    = 0;
    cyc        = 0;
    shadow[0]  = '0;
    shadow[1]  = MTVEC_RST;
    shadow[2]  = '0;
    shadow[3]  = '0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;
    i_ready  = 1'b1;
    @(negedge i_clk);

    // Latency of a lone request
    i_rs1 = 32'd5;
    i_rs2 = 32'd7;
    issue_and_wait();
    check_val("o_valid", W'(o_valid), W'(1'b0));
    @(negedge i_clk);
    check_val("o_valid", W'(o_valid), W'(1'b1));

    set_csr_request(exu_isa_pkg::CSR_RS, 1'b0, exu_isa_pkg::CSR_MTVEC, '0);
    issue_and_wait();
    set_csr_request(exu_isa_pkg::CSR_RW, 1'b1, 12'h7c0, 32'hdead_beef);
    issue_and_wait();
    set_csr_request(exu_isa_pkg::CSR_RS, 1'b0, 12'h7c0, '0);
    issue_and_wait();
    // Back to back on mepc so the second sees the first write
    set_csr_request(exu_isa_pkg::CSR_RW, 1'b1, exu_isa_pkg::CSR_MEPC, 32'h1234_5678);
    issue_and_wait();
    set_csr_request(exu_isa_pkg::CSR_RC, 1'b0, exu_isa_pkg::CSR_MEPC, 32'h0000_00f0);
    issue_and_wait();

    n_sent = N_DIRECTED;
    seen   = acc_cnt;
    while (acc_cnt < N_TXN) begin
      @(negedge i_clk);
      t       = take_bits(2);
      i_ready = (t[1:0] != 2'd0);
      if (i_valid && acc_cnt != seen) i_valid = 1'b0;
      seen = acc_cnt;
      if (!i_valid && n_sent < N_TXN) begin
        t = take_bits(2);
        if (t[1:0] != 2'd0) begin
          load_random_request();
          i_valid = 1'b1;
          n_sent++;
        end
      end
    end

    i_ready = 1'b1;
    while (exp_q.size() != 0) @(negedge i_clk);
    repeat (4) @(negedge i_clk);
    if (rsp_cnt != N_TXN) begin
      $display("Saw %0d responses for %0d accepted requests", rsp_cnt, acc_cnt);
      err_cnt++;
    end
    $display("Responses %0d of %0d, checks %0d, errors %0d", rsp_cnt, N_TXN, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== exu_stage.f ====
exu_isa_pkg.sv
exu_pkt_pkg.sv
csr_if.sv
alu.sv
exu.sv
csr_file.sv
exu_pipe_reg.sv
exu_stage.sv
exu_stage_chk.sv
tb_exu_stage.sv

// ==== Bender.yml ====
package:
  name: exu_stage

sources:
  - exu_isa_pkg.sv
  - exu_pkt_pkg.sv
  - csr_if.sv
  - alu.sv
  - exu.sv
  - csr_file.sv
  - exu_pipe_reg.sv
  - exu_stage.sv
  - target: test
    files:
      - exu_stage_chk.sv
      - tb_exu_stage.sv
